// ==== build.f ====
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/pipeIfs.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/writebackStage.sv
logic/legCore.sv
tb/tbClock.sv
tb/coreTb.sv

// ==== logic/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// ===========================================================================
// Core widths and register file geometry
// ===========================================================================

`define DATA_WIDTH    64     // Operand and result width
`define INSTR_WIDTH   32     // LEGv8 instruction word
`define REG_COUNT     32     // Architectural registers incl. zero reg
`define REG_IDX_WIDTH 5      // Bits to address one register
`define ZERO_REG      5'd31  // Always reads zero, writes dropped

`endif

// ==== logic/decodeStage.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module decodeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  logic [`INSTR_WIDTH-1:0] instr,
    output logic                   instrReady,
    decodeIf.source                dec,
    resultIf.sink                  res         // Commit side for reg file write
);

    isaPkg::instrU   word;        // Both format views of instr
    pipePkg::aluOpT  aluOpNext;
    logic            setFlagsNext;
    logic            useImmNext;
    logic            isRType;
    logic            legal;       // One of the eight kept opcodes
    isaPkg::regIdxT  rmIdx;
    pipePkg::wordT   rdDataA;
    pipePkg::wordT   rdDataB;

    assign word       = instr;
    assign instrReady = dec.advance;  // Accept whenever pipeline moves

    // ===================================================================
    // Opcode decode, R-type view first
    // ===================================================================
    always_comb begin
        aluOpNext    = pipePkg::ALU_ADD;
        setFlagsNext = 1'b0;
        useImmNext   = 1'b0;
        isRType      = 1'b1;
        legal        = 1'b1;
        case (word.r.opcode)
            isaPkg::OP_ADD:  aluOpNext = pipePkg::ALU_ADD;
            isaPkg::OP_SUB:  aluOpNext = pipePkg::ALU_SUB;
            isaPkg::OP_AND:  aluOpNext = pipePkg::ALU_AND;
            isaPkg::OP_ORR:  aluOpNext = pipePkg::ALU_ORR;
            isaPkg::OP_ADDS: begin
                aluOpNext    = pipePkg::ALU_ADD;
                setFlagsNext = 1'b1;
            end
            isaPkg::OP_SUBS: begin
                aluOpNext    = pipePkg::ALU_SUB;
                setFlagsNext = 1'b1;
            end
            default: begin
                isRType    = 1'b0;             // Fall back to I-type view
                useImmNext = 1'b1;
                case (word.i.opcode)
                    isaPkg::OP_ADDI: aluOpNext = pipePkg::ALU_ADD;
                    isaPkg::OP_SUBI: aluOpNext = pipePkg::ALU_SUB;
                    default:         legal     = 1'b0;
                endcase
            end
        endcase
    end

    // Rn/Rd sit in the same bits for both formats
    assign rmIdx = isRType ? word.r.rm : `ZERO_REG;  // No Rm read for I-type

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdIdxA  (word.i.rn),
        .rdIdxB  (rmIdx),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (res.commitValid && res.advance),  // Same as wbValid && wbReady
        .wrIdx   (res.commitRd),
        .wrData  (res.commitData)
    );

    // Decoded item register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dec.valid <= 1'b0;
        end else if (dec.advance) begin
            dec.valid <= instrValid;           // Bubble when nothing offered
        end
    end

    always_ff @(posedge clk) begin
        if (dec.advance) begin
            dec.aluOp    <= aluOpNext;
            dec.setFlags <= setFlagsNext;
            dec.useImm   <= useImmNext;
            dec.imm      <= pipePkg::wordT'(word.i.imm);  // Zero extend
            dec.rn       <= word.i.rn;
            dec.rm       <= rmIdx;
            dec.rd       <= word.i.rd;
            dec.opA      <= rdDataA;
            dec.opB      <= rdDataB;
        end
    end

    // Only the eight kept opcodes may be handed in
    assert property (@(posedge clk) disable iff (!rstN)
        (instrValid && instrReady) |-> legal)
        else $error("decodeStage: illegal opcode accepted");

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module executeStage (
    input  logic    clk,
    input  logic    rstN,
    decodeIf.sink   dec,
    resultIf.source res
);

    pipePkg::wordT           opA;       // After forwarding
    pipePkg::wordT           fwdB;
    pipePkg::wordT           opB;       // After imm select
    pipePkg::wordT           bEff;      // B or ~B
    pipePkg::wordT           aluResult;
    logic [`DATA_WIDTH:0]    sum;       // Extra bit is carry out
    logic                    isSub;
    logic                    isArith;
    pipePkg::flagsT          aluFlags;
    pipePkg::flagsT          flagReg;   // Architectural NZCV
    pipePkg::flagsT          flagsNext;

    assign dec.advance = res.advance;   // Decode follows writeback

    // ===================================================================
    // Forwarding, youngest producer wins
    // ===================================================================
    function automatic pipePkg::wordT fwdSel(
        input isaPkg::regIdxT src,
        input pipePkg::wordT  regVal,
        input logic           exValid,
        input isaPkg::regIdxT exRd,
        input pipePkg::wordT  exData,
        input logic           wbValid,
        input isaPkg::regIdxT wbRd,
        input pipePkg::wordT  wbData
    );
        if (src == `ZERO_REG) begin
            return regVal;                      // Reg file already gives zero
        end else if (exValid && (exRd == src)) begin
            return exData;                      // Previous instr, result reg
        end else if (wbValid && (wbRd == src)) begin
            return wbData;                      // Older instr, waiting record
        end else begin
            return regVal;
        end
    endfunction

    assign opA  = fwdSel(dec.rn, dec.opA, res.valid, res.rd, res.data,
                         res.commitValid, res.commitRd, res.commitData);
    assign fwdB = fwdSel(dec.rm, dec.opB, res.valid, res.rd, res.data,
                         res.commitValid, res.commitRd, res.commitData);
    assign opB  = dec.useImm ? dec.imm : fwdB;

    // ===================================================================
    // ALU and NZCV
    // ===================================================================
    always_comb begin
        isSub   = (dec.aluOp == pipePkg::ALU_SUB);
        isArith = (dec.aluOp == pipePkg::ALU_ADD) || isSub;
        bEff    = isSub ? ~opB : opB;
        sum     = {1'b0, opA} + {1'b0, bEff} + (`DATA_WIDTH+1)'(isSub);  // +1 for SUB
        case (dec.aluOp)
            pipePkg::ALU_AND: aluResult = opA & opB;
            pipePkg::ALU_ORR: aluResult = opA | opB;
            default:          aluResult = sum[`DATA_WIDTH-1:0];
        endcase
        aluFlags.n = aluResult[`DATA_WIDTH-1];
        aluFlags.z = (aluResult == '0);
        aluFlags.c = isArith && sum[`DATA_WIDTH];
        // Same-sign inputs, different-sign result
        aluFlags.v = isArith && (opA[`DATA_WIDTH-1] == bEff[`DATA_WIDTH-1])
                             && (aluResult[`DATA_WIDTH-1] != opA[`DATA_WIDTH-1]);
    end

    assign flagsNext = dec.setFlags ? aluFlags : flagReg;  // Flags seen after this instr

    always_ff @(posedge clk) begin
        if (!rstN) begin
            res.valid <= 1'b0;
            flagReg   <= '0;
        end else if (res.advance) begin
            res.valid <= dec.valid;
            if (dec.valid && dec.setFlags) begin
                flagReg <= aluFlags;            // ADDS / SUBS only
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res.advance) begin
            res.rd    <= dec.rd;
            res.data  <= aluResult;
            res.flags <= flagsNext;
        end
    end

    // Stage valids stay known once out of reset
    assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown({dec.valid, res.valid, res.commitValid}))
        else $error("executeStage: unknown valid in pipeline");

endmodule

// ==== logic/isaPkg.sv ====
`include "core_params.svh"

package isaPkg;

    typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;  // Register index

    // =======================================================================
    // Instruction formats
    // =======================================================================

    typedef struct packed {
        logic [10:0] opcode;  // Bits 31:21
        regIdxT      rm;      // Second source
        logic [5:0]  shamt;   // Not used by the kept opcodes
        regIdxT      rn;      // First source
        regIdxT      rd;      // Destination
    } rTypeT;

    typedef struct packed {
        logic [9:0]  opcode;  // Bits 31:22
        logic [11:0] imm;     // Zero-extended at decode
        regIdxT      rn;
        regIdxT      rd;
    } iTypeT;

    // Same 32-bit word seen as either format
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrU;

    // R-type opcodes, 11 bits
    parameter logic [10:0] OP_ADD  = 11'b10001011000;
    parameter logic [10:0] OP_SUB  = 11'b11001011000;
    parameter logic [10:0] OP_AND  = 11'b10001010000;
    parameter logic [10:0] OP_ORR  = 11'b10101010000;
    parameter logic [10:0] OP_ADDS = 11'b10101011000;
    parameter logic [10:0] OP_SUBS = 11'b11101011000;
    // I-type opcodes, 10 bits
    parameter logic [9:0]  OP_ADDI = 10'b1001000100;
    parameter logic [9:0]  OP_SUBI = 10'b1101000100;

endpackage

// ==== logic/legCore.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module legCore (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    instrValid,
    input  logic [`INSTR_WIDTH-1:0] instr,
    output logic                    instrReady,
    output logic                    wbValid,
    output isaPkg::regIdxT          wbReg,
    output pipePkg::wordT           wbData,
    output pipePkg::flagsT          wbFlags,
    input  logic                    wbReady
);

    // ===================================================================
    // Stage links
    // ===================================================================
    decodeIf decIf ();  // Decode -> execute
    resultIf resIf ();  // Execute -> writeback, commit fed back

    decodeStage decode_i (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .instrReady (instrReady),
        .dec        (decIf.source),
        .res        (resIf.sink)
    );

    executeStage execute_i (
        .clk  (clk),
        .rstN (rstN),
        .dec  (decIf.sink),
        .res  (resIf.source)
    );

    writebackStage writeback_i (
        .clk     (clk),
        .rstN    (rstN),
        .res     (resIf.sink),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData),
        .wbFlags (wbFlags),
        .wbReady (wbReady)
    );

endmodule

// ==== logic/pipeIfs.sv ====
`timescale 1ns/100ps

// Decode to execute, one decoded instruction
interface decodeIf;
    logic            valid;     // Item held in decode register
    pipePkg::aluOpT  aluOp;     // ALU function
    logic            setFlags;  // ADDS / SUBS
    logic            useImm;    // B operand from imm
    pipePkg::wordT   imm;       // Zero-extended imm12
    isaPkg::regIdxT  rn;        // Source of opA
    isaPkg::regIdxT  rm;        // Source of opB, ZERO_REG for I-type
    isaPkg::regIdxT  rd;        // Destination
    pipePkg::wordT   opA;       // Value read at decode
    pipePkg::wordT   opB;       // Value read at decode
    logic            advance;   // Pipeline moves this edge

    modport source (output valid, aluOp, setFlags, useImm, imm, rn, rm, rd, opA, opB,
                    input  advance);
    modport sink   (input  valid, aluOp, setFlags, useImm, imm, rn, rm, rd, opA, opB,
                    output advance);
endinterface

// Execute to writeback, plus the committed record fed back
interface resultIf;
    logic            valid;       // Execute result register full
    isaPkg::regIdxT  rd;
    pipePkg::wordT   data;
    pipePkg::flagsT  flags;       // Flag reg after this instr
    logic            advance;     // Writeback empty or consumer takes it
    logic            commitValid; // Writeback record full
    isaPkg::regIdxT  commitRd;
    pipePkg::wordT   commitData;

    modport source (output valid, rd, data, flags,
                    input  advance, commitValid, commitRd, commitData);
    modport sink   (input  valid, rd, data, flags,
                    output advance, commitValid, commitRd, commitData);
endinterface

// ==== logic/pipePkg.sv ====
`include "core_params.svh"

package pipePkg;

    // =======================================================================
    // Pipeline payload types
    // =======================================================================

    typedef logic [`DATA_WIDTH-1:0] wordT;  // Operand / result word

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,  // A + B
        ALU_SUB = 2'd1,  // A + ~B + 1
        ALU_AND = 2'd2,  // Bitwise and
        ALU_ORR = 2'd3   // Bitwise or
    } aluOpT;

    // NZCV condition flags
    typedef struct packed {
        logic n;  // Negative
        logic z;  // Zero
        logic c;  // Carry out
        logic v;  // Signed overflow
    } flagsT;

endpackage

// ==== logic/regFile.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::regIdxT rdIdxA,
    input  isaPkg::regIdxT rdIdxB,
    output pipePkg::wordT  rdDataA,
    output pipePkg::wordT  rdDataB,
    input  logic           wrEn,     // Output handshake
    input  isaPkg::regIdxT wrIdx,
    input  pipePkg::wordT  wrData
);

    pipePkg::wordT regs [0:`REG_COUNT-2];  // X0..X30, X31 not stored

    // One read port, shared by A and B
    function automatic pipePkg::wordT readPort(
        input isaPkg::regIdxT idx,
        input pipePkg::wordT  stored,
        input logic           wen,
        input isaPkg::regIdxT widx,
        input pipePkg::wordT  wdata
    );
        if (idx == `ZERO_REG) begin
            return '0;                        // XZR
        end else if (wen && (widx == idx)) begin
            return wdata;                     // Write-through, same cycle
        end else begin
            return stored;
        end
    endfunction

    assign rdDataA = readPort(rdIdxA, regs[rdIdxA], wrEn, wrIdx, wrData);
    assign rdDataB = readPort(rdIdxB, regs[rdIdxB], wrEn, wrIdx, wrData);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT - 1; i++) begin
                regs[i] <= '0;                // Architectural state starts at zero
            end
        end else if (wrEn && (wrIdx != `ZERO_REG)) begin
            regs[wrIdx] <= wrData;            // Writes to X31 dropped
        end
    end

endmodule

// ==== logic/writebackStage.sv ====
`timescale 1ns/100ps

module writebackStage (
    input  logic           clk,
    input  logic           rstN,
    resultIf.sink          res,
    output logic           wbValid,
    output isaPkg::regIdxT wbReg,
    output pipePkg::wordT  wbData,
    output pipePkg::flagsT wbFlags,
    input  logic           wbReady
);

    // Empty slot or record leaving this edge
    assign res.advance = !res.commitValid || wbReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            res.commitValid <= 1'b0;
        end else if (res.advance) begin
            res.commitValid <= res.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res.advance) begin
            res.commitRd   <= res.rd;
            res.commitData <= res.data;
            wbFlags        <= res.flags;  // Flags only go out, never forwarded
        end
    end

    assign wbValid = res.commitValid;
    assign wbReg   = res.commitRd;
    assign wbData  = res.commitData;

    // Stalled record holds until the consumer takes it
    assert property (@(posedge clk) disable iff (!rstN)
        (wbValid && !wbReady) |=>
            (wbValid && $stable(wbReg) && $stable(wbData) && $stable(wbFlags)))
        else $error("writebackStage: record changed while stalled");

endmodule

// ==== tb/coreTb.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module coreTb;

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = NUM_INSTR * 10;  // Ample for 80% offer and 70% ready

    logic                    clk;
    logic                    rstN;
    logic                    instrValid;
    logic [`INSTR_WIDTH-1:0] instr;
    logic                    instrReady;
    logic                    wbValid;
    isaPkg::regIdxT          wbReg;
    pipePkg::wordT           wbData;
    pipePkg::flagsT          wbFlags;
    logic                    wbReady;

    logic [31:0]    rngState = 32'hd47d;          // LCG state
    pipePkg::wordT  modelRegs [0:`REG_COUNT-1];   // Architectural model
    pipePkg::flagsT modelFlags;
    isaPkg::regIdxT expRd [$];                    // Expected records, in order
    pipePkg::wordT  expData [$];
    pipePkg::flagsT expFlags [$];
    int             cycleCount = 0;
    int             sentCount = 0;
    int             recvCount = 0;
    logic [2:0]     pendOp;                       // 0..5 R-type, 6 ADDI, 7 SUBI
    isaPkg::regIdxT pendRn;
    isaPkg::regIdxT pendRm;
    isaPkg::regIdxT pendRd;
    logic [11:0]    pendImm;
    logic           stallPending = 1'b0;          // Last edge saw a stalled record
    isaPkg::regIdxT heldReg;
    pipePkg::wordT  heldData;
    pipePkg::flagsT heldFlags;

    tbClock clkGen_i (.clk(clk));

    legCore legCore_i (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .instrReady (instrReady),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .wbFlags    (wbFlags),
        .wbReady    (wbReady)
    );

    // ========================================================================
    // Random source and instruction builder
    // ========================================================================
    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return {16'b0, rngState[31:16]};  // Upper bits, low ones cycle fast
    endfunction

    function automatic isaPkg::regIdxT pickReg();
        logic [31:0] r;
        r = nextRand();
        if (r % 100 < 65) begin
            return isaPkg::regIdxT'((r / 100) % 4);   // Dense reuse forces forwarding
        end else if (r % 100 < 75) begin
            return `ZERO_REG;
        end
        return isaPkg::regIdxT'((r / 100) % 32);
    endfunction

    function automatic logic [31:0] encode(input logic [2:0] op, input isaPkg::regIdxT rn,
                                           input isaPkg::regIdxT rm, input isaPkg::regIdxT rd,
                                           input logic [11:0] imm);
        isaPkg::instrU w;
        w      = '0;
        w.r.rn = rn;
        w.r.rd = rd;
        if (op < 3'd6) begin
            w.r.rm = rm;
            case (op)
                3'd0:    w.r.opcode = isaPkg::OP_ADD;
                3'd1:    w.r.opcode = isaPkg::OP_SUB;
                3'd2:    w.r.opcode = isaPkg::OP_AND;
                3'd3:    w.r.opcode = isaPkg::OP_ORR;
                3'd4:    w.r.opcode = isaPkg::OP_ADDS;
                default: w.r.opcode = isaPkg::OP_SUBS;
            endcase
        end else begin
            w.i.imm    = imm;
            w.i.opcode = (op == 3'd6) ? isaPkg::OP_ADDI : isaPkg::OP_SUBI;
        end
        return w;
    endfunction

    task automatic newOffer();
        pendOp  = 3'(nextRand() % 8);
        pendRn  = pickReg();
        pendRm  = pickReg();
        pendRd  = pickReg();
        pendImm = 12'(nextRand());
    endtask

    // ========================================================================
    // Reference model, one accepted instruction at a time
    // ========================================================================
    task automatic applyModel();
        pipePkg::wordT       a;
        pipePkg::wordT       b;
        pipePkg::wordT       res;
        logic [`DATA_WIDTH:0] sum;
        logic                isSub;
        a     = (pendRn == `ZERO_REG) ? '0 : modelRegs[pendRn];
        b     = (pendRm == `ZERO_REG) ? '0 : modelRegs[pendRm];
        b     = (pendOp >= 3'd6) ? pipePkg::wordT'(pendImm) : b;  // Zero-extended imm12
        isSub = (pendOp == 3'd1) || (pendOp == 3'd5) || (pendOp == 3'd7);
        if (isSub) begin
            sum = {1'b0, a} + {1'b0, ~b} + 1'b1;  // Carry of A + ~B + 1
        end else begin
            sum = {1'b0, a} + {1'b0, b};
        end
        case (pendOp)
            3'd2:    res = a & b;
            3'd3:    res = a | b;
            default: res = sum[`DATA_WIDTH-1:0];
        endcase
        if (pendOp == 3'd4 || pendOp == 3'd5) begin  // ADDS / SUBS only
            modelFlags.n = res[`DATA_WIDTH-1];
            modelFlags.z = (res == '0);
            modelFlags.c = sum[`DATA_WIDTH];
            if (isSub) begin
                modelFlags.v = (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1])
                               && (res[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
            end else begin
                modelFlags.v = (a[`DATA_WIDTH-1] == b[`DATA_WIDTH-1])
                               && (res[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
            end
        end
        if (pendRd != `ZERO_REG) begin
            modelRegs[pendRd] = res;  // XZR result is dropped
        end
        expRd.push_back(pendRd);
        expData.push_back(res);
        expFlags.push_back(modelFlags);
    endtask

    // ========================================================================
    // Checks
    // ========================================================================
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkReg(input isaPkg::regIdxT got, input isaPkg::regIdxT exp,
                            input string what);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0t: %s got %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic checkData(input pipePkg::wordT got, input pipePkg::wordT exp,
                             input string what);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkFlags(input pipePkg::flagsT got, input pipePkg::flagsT exp,
                              input string what);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %0t: %s got NZCV %b, expected %b", $time, what, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            abortRun($sformatf("Timeout after %0d cycles with %0d of %0d records received",
                               cycleCount, recvCount, NUM_INSTR));
        end
    end

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        wbReady    = 1'b0;
        modelFlags = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        repeat (5) @(posedge clk);
        if (wbValid !== 1'b0 || instrReady !== 1'b1) begin
            abortRun($sformatf("[FAIL] %0t: after reset wbValid is %b and instrReady is %b",
                               $time, wbValid, instrReady));
        end
        rstN <= 1'b1;
        while (recvCount < NUM_INSTR) begin
            @(posedge clk);
            if (instrValid && instrReady) begin  // Input handshake at this edge
                applyModel();
                sentCount++;
            end
            if (stallPending) begin
                if (wbValid !== 1'b1) begin
                    abortRun($sformatf("[FAIL] %0t: wbValid dropped while its record was stalled",
                                       $time));
                end
                checkReg(wbReg, heldReg, "stalled wbReg");
                checkData(wbData, heldData, "stalled wbData");
                checkFlags(wbFlags, heldFlags, "stalled wbFlags");
            end
            if (wbValid && wbReady) begin
                if (expRd.size() == 0) begin
                    abortRun("A record retired with no instruction outstanding");
                end
                checkReg(wbReg, expRd.pop_front(), "wbReg");
                checkData(wbData, expData.pop_front(), "wbData");
                checkFlags(wbFlags, expFlags.pop_front(), "wbFlags");
                recvCount++;
            end
            stallPending = wbValid && !wbReady;
            heldReg      = wbReg;
            heldData     = wbData;
            heldFlags    = wbFlags;
            if (!(instrValid && !instrReady)) begin  // Refused offer stays on the bus
                if (sentCount < NUM_INSTR && (nextRand() % 10) < 8) begin
                    newOffer();
                    instr      <= encode(pendOp, pendRn, pendRm, pendRd, pendImm);
                    instrValid <= 1'b1;
                end else begin
                    instrValid <= 1'b0;
                end
            end
            wbReady <= (nextRand() % 10) >= 3;  // Low about 30% of cycles
        end
        if (expRd.size() != 0 || sentCount != NUM_INSTR) begin
            abortRun("Instruction count and record count do not match at the end");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// ==== tb/tbClock.sv ====
`timescale 1ns/100ps

module tbClock #(
    parameter int PERIOD = 10  // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;  // Known level before first edge
    end

    always begin
        #(PERIOD / 2) clk = ~clk;  // Half period high, half low
    end

endmodule
